// ==== dv/rx_frontend_sva.sv ====
`timescale 1ns/10ps

module rx_frontend_sva #(
    parameter int BUF_DEPTH    = 8,
    parameter int DOWN_CREDITS = 4
) (
    input logic                           clk_i,
    input logic                           reset_ni,
    input logic                           push_i,
    input logic                           pop_i,
    input logic                           out_valid_i,
    input logic                           out_credit_i,
    input logic                           in_credit_i,
    input logic [$clog2(BUF_DEPTH+1)-1:0] count_i
);

    // downstream credits as the sink sees them
    int sink_credits;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            sink_credits <= DOWN_CREDITS;
        end else begin
            sink_credits <= sink_credits + int'(out_credit_i) - int'(out_valid_i);
        end
    end

    // ------------------------------
    // credit protocol
    // ------------------------------
    a_send_needs_credit: assert property (@(posedge clk_i) disable iff (!reset_ni)
        out_valid_i |-> (sink_credits > 0))
        else $error("out_valid_o with no downstream credit");

    // a full fifo may only take a write while it is read
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!reset_ni)
        (push_i && !pop_i) |-> (count_i < BUF_DEPTH))
        else $error("write into a full fifo");

    // each returned credit frees one held entry
    a_credit_with_pop: assert property (@(posedge clk_i) disable iff (!reset_ni)
        in_credit_i |=> ($past(count_i) != '0)
                        && (count_i + 1 == $past(count_i) + $past(push_i)))
        else $error("in_credit_o without a pop");

endmodule

bind credit_out_buffer rx_frontend_sva #(
    .BUF_DEPTH    (BUF_DEPTH),
    .DOWN_CREDITS (DOWN_CREDITS)
) i_buffer_sva (
    .clk_i        (clk_i),
    .reset_ni     (reset_ni),
    .push_i       (push),
    .pop_i        (pop),
    .out_valid_i  (out_valid_o),
    .out_credit_i (out_credit_i),
    .in_credit_i  (in_credit_o),
    .count_i      (count)
);

// ==== dv/rx_frontend_tb.sv ====
`timescale 1ns/10ps

module rx_frontend_tb;

    localparam int BUF_DEPTH    = 8;
    localparam int DOWN_CREDITS = 4;
    localparam int CLK_PERIOD   = 8;
    localparam int N_ZERO       = 150;
    localparam int N_CFO        = 250;
    localparam int N_MODE       = 100;
    localparam int N_AFTER      = 100;
    localparam int NUM_SAMPLES  = N_ZERO + N_CFO + N_MODE + N_AFTER;
    localparam longint IQ_MAX   = 2**(rx_frontend_pkg::IQ_W - 1) - 1;
    localparam longint IQ_MIN   = -IQ_MAX - 1;

    logic                      clk;
    logic                      reset_n;
    logic                      in_valid;
    rx_frontend_pkg::iq_word_u in_sample;
    logic                      in_credit;
    logic                      cfo_valid;
    rx_frontend_pkg::phase_t   cfo_inc;
    logic                      cfo_mode;
    logic                      out_valid;
    rx_frontend_pkg::iq_word_u out_sample;
    logic                      out_credit;

    // reference model state
    rx_frontend_pkg::phase_t   model_phase;
    rx_frontend_pkg::phase_t   model_inc;
    rx_frontend_pkg::iq_word_u exp_q [$];

    integer seed;
    int     src_credits;
    int     sent;
    int     delivered;
    int     granted;
    int     owed;
    int     cycle_cnt;
    int     pending [16];

    rx_frontend_top #(
        .BUF_DEPTH    (BUF_DEPTH),
        .DOWN_CREDITS (DOWN_CREDITS)
    ) i_dut (
        .clk_i        (clk),
        .reset_ni     (reset_n),
        .in_valid_i   (in_valid),
        .in_sample_i  (in_sample),
        .in_credit_o  (in_credit),
        .cfo_valid_i  (cfo_valid),
        .cfo_inc_i    (cfo_inc),
        .cfo_mode_i   (cfo_mode),
        .out_valid_o  (out_valid),
        .out_sample_o (out_sample),
        .out_credit_i (out_credit)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic stop_on_error(input string what);
        $display("error at %0t: %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic signed [rx_frontend_pkg::IQ_W-1:0] clip_iq(input longint v);
        if (v > IQ_MAX) begin
            return IQ_MAX[rx_frontend_pkg::IQ_W-1:0];
        end else if (v < IQ_MIN) begin
            return IQ_MIN[rx_frontend_pkg::IQ_W-1:0];
        end
        return v[rx_frontend_pkg::IQ_W-1:0];
    endfunction

    // de-rotation of one sample by the table entry for its phase
    function automatic rx_frontend_pkg::iq_word_u rotate_model(
        input rx_frontend_pkg::iq_word_u smp,
        input rx_frontend_pkg::phase_t   phase
    );
        logic signed [rx_frontend_pkg::IQ_W-1:0] c;
        logic signed [rx_frontend_pkg::IQ_W-1:0] s;
        longint                                  re_l;
        longint                                  im_l;
        rx_frontend_pkg::iq_word_u               res;
        rx_frontend_pkg::rot_lookup(phase, c, s);
        re_l = longint'(smp.iq.re) * longint'(c) - longint'(smp.iq.im) * longint'(s);
        im_l = longint'(smp.iq.re) * longint'(s) + longint'(smp.iq.im) * longint'(c);
        res.iq.re = clip_iq(re_l >>> rx_frontend_pkg::COEF_FRAC);
        res.iq.im = clip_iq(im_l >>> rx_frontend_pkg::COEF_FRAC);
        return res;
    endfunction

    // ------------------------------
    // one clock of source, model and sink
    // ------------------------------
    task automatic run_cycle(input bit want_send, input bit cfo_en, input bit mode);
        rx_frontend_pkg::iq_word_u smp;
        rx_frontend_pkg::iq_word_u exp_word;
        logic [2:0]                kind;
        @(posedge clk);
        #1;
        owed = owed + pending[cycle_cnt % 16];
        pending[cycle_cnt % 16] = 0;
        out_credit = (owed != 0);
        if (owed != 0) begin
            owed = owed - 1;
        end
        smp.raw = $random(seed);
        kind    = 3'($random(seed));
        // full-scale corners now and then
        if (kind == 3'd0) begin
            smp.iq.re = ($random(seed) & 1) ? 16'h7fff : 16'h8000;
            smp.iq.im = ($random(seed) & 1) ? 16'h7fff : 16'h8000;
        end
        in_valid  = want_send && (src_credits > 0) && (($random(seed) & 3) != 0);
        in_sample = smp;
        cfo_valid = cfo_en && (($random(seed) & 7) == 0);
        cfo_inc   = rx_frontend_pkg::phase_t'($random(seed));
        cfo_mode  = mode;
        if (in_valid) begin
            exp_q.push_back(rotate_model(smp, model_phase));
            src_credits = src_credits - 1;
            sent = sent + 1;
        end
        if (mode) begin
            model_phase = '0;
            model_inc   = '0;
        end else begin
            // phase advances with the increment from before this cycle
            if (in_valid) begin
                model_phase = model_phase + model_inc;
            end
            if (cfo_valid) begin
                model_inc = model_inc - cfo_inc;
            end
        end
        @(negedge clk);
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                stop_on_error("out_valid_o fired with no sample pending");
            end else begin
                delivered = delivered + 1;
                if (delivered > granted) begin
                    stop_on_error("out_valid_o fired more often than credits were granted");
                end
                exp_word = exp_q.pop_front();
                check_value("out_sample_o", out_sample.raw, exp_word.raw);
                pending[(cycle_cnt + 1 + ($unsigned($random(seed)) % 8)) % 16] += 1;
            end
        end
        if (in_credit) begin
            src_credits = src_credits + 1;
        end
        check_value("in_credit_o", in_credit, out_valid);
        if (out_credit) begin
            granted = granted + 1;
        end
        cycle_cnt = cycle_cnt + 1;
    endtask

    task automatic send_samples(input int n, input bit cfo_en, input bit mode);
        int target;
        target = sent + n;
        while (sent < target) begin
            run_cycle(1'b1, cfo_en, mode);
        end
    endtask

    initial begin
        seed        = 32'hf3e7bcdc;
        reset_n     = 1'b0;
        in_valid    = 1'b0;
        in_sample   = '0;
        cfo_valid   = 1'b0;
        cfo_inc     = '0;
        cfo_mode    = 1'b0;
        out_credit  = 1'b0;
        model_phase = '0;
        model_inc   = '0;
        src_credits = BUF_DEPTH;
        sent        = 0;
        delivered   = 0;
        granted     = DOWN_CREDITS;
        owed        = 0;
        cycle_cnt   = 0;
        foreach (pending[i]) begin
            pending[i] = 0;
        end
        repeat (3) begin
            @(negedge clk);
            check_value("out_valid_o", out_valid, 1'b0);
            check_value("in_credit_o", in_credit, 1'b0);
        end
        @(posedge clk);
        #1;
        reset_n = 1'b1;
        // idle first, nothing may come out
        repeat (6) run_cycle(1'b0, 1'b0, 1'b0);
        send_samples(N_ZERO, 1'b0, 1'b0);
        send_samples(N_CFO, 1'b1, 1'b0);
        send_samples(N_MODE, 1'b1, 1'b1);
        send_samples(N_AFTER, 1'b1, 1'b0);
        while (exp_q.size() != 0) begin
            run_cycle(1'b0, 1'b0, 1'b0);
        end
        repeat (4) run_cycle(1'b0, 1'b0, 1'b0);
        $display("ALL CHECKS PASSED");
        $finish;
    end

    // watchdog
    initial begin
        #(NUM_SAMPLES * 40 * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", NUM_SAMPLES * 40);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== flist.f ====
hdl/rx_frontend_pkg.sv
hdl/cfo_phase_accum.sv
hdl/rotator_lut.sv
hdl/complex_rotator.sv
hdl/credit_out_buffer.sv
hdl/rx_frontend_top.sv
dv/rx_frontend_sva.sv
dv/rx_frontend_tb.sv

// ==== hdl/cfo_phase_accum.sv ====
`timescale 1ns/10ps

module cfo_phase_accum (
    input  logic                            clk_i,
    input  logic                            reset_ni,
    input  logic                            valid_i,
    input  rx_frontend_pkg::iq_word_u       sample_i,
    input  logic                            cfo_valid_i,
    input  rx_frontend_pkg::phase_t         cfo_inc_i,
    input  logic                            cfo_mode_i,
    output logic                            valid_o,
    output rx_frontend_pkg::phased_sample_t data_o
);

    rx_frontend_pkg::phase_t inc_q;
    rx_frontend_pkg::phase_t phase_q;

    // increment updates are relative to the previous estimate
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            inc_q   <= '0;
            phase_q <= '0;
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
            if (cfo_mode_i) begin
                // manual CFO mode
                inc_q   <= '0;
                phase_q <= '0;
            end else begin
                if (cfo_valid_i) begin
                    inc_q <= inc_q - cfo_inc_i;
                end
                if (valid_i) begin
                    phase_q <= phase_q + inc_q;
                end
            end
        end
    end

    // sample leaves with the phase it arrived on
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            data_o.sample <= sample_i;
            data_o.phase  <= phase_q;
        end
    end

endmodule

// ==== hdl/complex_rotator.sv ====
`timescale 1ns/10ps

module complex_rotator (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  logic                      valid_i,
    input  rx_frontend_pkg::rot_op_t  data_i,
    output logic                      valid_o,
    output rx_frontend_pkg::iq_word_u sample_o
);

    localparam int IQ_W   = rx_frontend_pkg::IQ_W;
    localparam int PROD_W = 2 * IQ_W;
    localparam int SUM_W  = PROD_W + 1;
    localparam logic signed [SUM_W-1:0] SAT_MAX = SUM_W'(2**(IQ_W-1) - 1);
    localparam logic signed [SUM_W-1:0] SAT_MIN = -SAT_MAX - 1;

    logic                    prod_valid;
    logic signed [PROD_W-1:0] p_re_cos;
    logic signed [PROD_W-1:0] p_im_sin;
    logic signed [PROD_W-1:0] p_re_sin;
    logic signed [PROD_W-1:0] p_im_cos;
    logic signed [SUM_W-1:0]  sum_re;
    logic signed [SUM_W-1:0]  sum_im;

    // drop the coefficient fraction bits, then clip to IQ_W
    function automatic logic signed [IQ_W-1:0] scale_sat(input logic signed [SUM_W-1:0] v);
        logic signed [SUM_W-1:0] s;
        s = v >>> rx_frontend_pkg::COEF_FRAC;
        if (s > SAT_MAX) begin
            return SAT_MAX[IQ_W-1:0];
        end else if (s < SAT_MIN) begin
            return SAT_MIN[IQ_W-1:0];
        end
        return s[IQ_W-1:0];
    endfunction

    // ------------------------------
    // stage 3, products
    // ------------------------------
    always_ff @(posedge clk_i) begin
        p_re_cos <= data_i.sample.iq.re * data_i.cos_v;
        p_im_sin <= data_i.sample.iq.im * data_i.sin_v;
        p_re_sin <= data_i.sample.iq.re * data_i.sin_v;
        p_im_cos <= data_i.sample.iq.im * data_i.cos_v;
    end

    // ------------------------------
    // stage 4, combine and scale
    // ------------------------------
    always_comb begin
        sum_re = p_re_cos - p_im_sin;
        sum_im = p_re_sin + p_im_cos;
    end

    always_ff @(posedge clk_i) begin
        sample_o.iq.re <= scale_sat(sum_re);
        sample_o.iq.im <= scale_sat(sum_im);
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            prod_valid <= 1'b0;
            valid_o    <= 1'b0;
        end else begin
            prod_valid <= valid_i;
            valid_o    <= prod_valid;
        end
    end

endmodule

// ==== hdl/credit_out_buffer.sv ====
`timescale 1ns/10ps

module credit_out_buffer #(
    parameter int BUF_DEPTH    = 8,
    parameter int DOWN_CREDITS = 4
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  logic                      valid_i,
    input  rx_frontend_pkg::iq_word_u sample_i,
    input  logic                      out_credit_i,
    output logic                      out_valid_o,
    output rx_frontend_pkg::iq_word_u out_sample_o,
    output logic                      in_credit_o
);

    localparam int PTR_W  = $clog2(BUF_DEPTH);
    localparam int CNT_W  = $clog2(BUF_DEPTH + 1);
    localparam int CRED_W = $clog2(DOWN_CREDITS + 1);

    rx_frontend_pkg::iq_word_u mem [BUF_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credits;
    logic              push;
    logic              pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(BUF_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // no ready upstream, input credits keep the fifo from filling
    assign push = valid_i;
    // send only with data and a downstream credit
    assign pop  = (count != '0) && (credits != '0);

    assign out_valid_o  = pop;
    assign out_sample_o = mem[rd_ptr];
    // freed slot goes straight back to the source
    assign in_credit_o  = pop;

    // ------------------------------
    // storage
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= sample_i;
        end
    end

    // ------------------------------
    // pointers and counters
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CRED_W'(DOWN_CREDITS);
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count   <= count + CNT_W'(push) - CNT_W'(pop);
            credits <= credits + CRED_W'(out_credit_i) - CRED_W'(pop);
        end
    end

endmodule

// ==== hdl/rotator_lut.sv ====
`timescale 1ns/10ps

module rotator_lut (
    input  logic                            clk_i,
    input  logic                            reset_ni,
    input  logic                            valid_i,
    input  rx_frontend_pkg::phased_sample_t data_i,
    output logic                            valid_o,
    output rx_frontend_pkg::rot_op_t        data_o
);

    logic signed [rx_frontend_pkg::IQ_W-1:0] cos_w;
    logic signed [rx_frontend_pkg::IQ_W-1:0] sin_w;

    always_comb begin
        rx_frontend_pkg::rot_lookup(data_i.phase, cos_w, sin_w);
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        data_o.sample <= data_i.sample;
        data_o.cos_v  <= cos_w;
        data_o.sin_v  <= sin_w;
    end

endmodule

// ==== hdl/rx_frontend_pkg.sv ====
package rx_frontend_pkg;

    // ------------------------------
    // widths
    // ------------------------------
    localparam int IQ_W       = 16;
    localparam int SAMPLE_W   = 2 * IQ_W;
    localparam int PHASE_W    = 20;
    localparam int LUT_ADDR_W = 4;
    localparam int COEF_FRAC  = 14;

    // ------------------------------
    // types
    // ------------------------------
    typedef struct packed {
        logic signed [IQ_W-1:0] im;
        logic signed [IQ_W-1:0] re;
    } iq_t;

    // source side sees a raw word, rotator sees the I/Q pair
    typedef union packed {
        logic [SAMPLE_W-1:0] raw;
        iq_t                 iq;
    } iq_word_u;

    typedef logic signed [PHASE_W-1:0] phase_t;

    typedef struct packed {
        iq_word_u sample;
        phase_t   phase;
    } phased_sample_t;

    typedef struct packed {
        iq_word_u               sample;
        logic signed [IQ_W-1:0] cos_v;
        logic signed [IQ_W-1:0] sin_v;
    } rot_op_t;

    // cosine in steps of 22.5 deg, scaled by 2^COEF_FRAC
    localparam logic signed [IQ_W-1:0] ROT_TABLE [2**LUT_ADDR_W] = '{
        16383,  15137,  11585,   6270,
            0,  -6270, -11585, -15137,
       -16384, -15137, -11585,  -6270,
            0,   6270,  11585,  15137
    };

    // sine is the cosine a quarter turn back
    function automatic void rot_lookup(
        input  phase_t                 phase,
        output logic signed [IQ_W-1:0] cos_v,
        output logic signed [IQ_W-1:0] sin_v
    );
        logic [LUT_ADDR_W-1:0] cos_idx;
        logic [LUT_ADDR_W-1:0] sin_idx;
        cos_idx = phase[PHASE_W-1 -: LUT_ADDR_W];
        sin_idx = cos_idx - LUT_ADDR_W'(2**(LUT_ADDR_W-2));
        cos_v   = ROT_TABLE[cos_idx];
        sin_v   = ROT_TABLE[sin_idx];
    endfunction

endpackage

// ==== hdl/rx_frontend_top.sv ====
`timescale 1ns/10ps

module rx_frontend_top #(
    parameter int BUF_DEPTH    = 8,
    parameter int DOWN_CREDITS = 4
) (
    input  logic                      clk_i,
    input  logic                      reset_ni,
    input  logic                      in_valid_i,
    input  rx_frontend_pkg::iq_word_u in_sample_i,
    output logic                      in_credit_o,
    input  logic                      cfo_valid_i,
    input  rx_frontend_pkg::phase_t   cfo_inc_i,
    input  logic                      cfo_mode_i,
    output logic                      out_valid_o,
    output rx_frontend_pkg::iq_word_u out_sample_o,
    input  logic                      out_credit_i
);

    logic                            s1_valid;
    rx_frontend_pkg::phased_sample_t s1_data;
    logic                            s2_valid;
    rx_frontend_pkg::rot_op_t        s2_data;
    logic                            s4_valid;
    rx_frontend_pkg::iq_word_u       s4_sample;

    cfo_phase_accum i_phase_accum (
        .clk_i       (clk_i),
        .reset_ni    (reset_ni),
        .valid_i     (in_valid_i),
        .sample_i    (in_sample_i),
        .cfo_valid_i (cfo_valid_i),
        .cfo_inc_i   (cfo_inc_i),
        .cfo_mode_i  (cfo_mode_i),
        .valid_o     (s1_valid),
        .data_o      (s1_data)
    );

    rotator_lut i_rotator_lut (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .valid_i  (s1_valid),
        .data_i   (s1_data),
        .valid_o  (s2_valid),
        .data_o   (s2_data)
    );

    complex_rotator i_complex_rotator (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .valid_i  (s2_valid),
        .data_i   (s2_data),
        .valid_o  (s4_valid),
        .sample_o (s4_sample)
    );

    credit_out_buffer #(
        .BUF_DEPTH    (BUF_DEPTH),
        .DOWN_CREDITS (DOWN_CREDITS)
    ) i_out_buffer (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .valid_i      (s4_valid),
        .sample_i     (s4_sample),
        .out_credit_i (out_credit_i),
        .out_valid_o  (out_valid_o),
        .out_sample_o (out_sample_o),
        .in_credit_o  (in_credit_o)
    );

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the rx front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module rx_frontend_tb \
    -Mdir obj_dir -o rx_frontend_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit $status
fi

./obj_dir/rx_frontend_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0
